/* hdl/ldq_defines.svh */
`ifndef LDQ_DEFINES_SVH
`define LDQ_DEFINES_SVH

// load queue depth
`define LDQ_SIZE 4

// virtual and physical address width
`define LDQ_ADDR_W 32

// commit id, top bit is the wrap bit
`define LDQ_CMT_ID_W 6

// miss queue entries, one-hot index width
`define LDQ_LRQ_SIZE 4

// store queue entries, hazard mask width
`define LDQ_STQ_SIZE 8

`endif

/* hdl/ldq_pkg.sv */
`include "ldq_defines.svh"

package ldq_pkg;

  localparam int LDQ_IDX_W = $clog2(`LDQ_SIZE);

  typedef logic [LDQ_IDX_W-1:0]     ldq_idx_t;
  typedef logic [`LDQ_CMT_ID_W-1:0] cmt_id_t;
  typedef logic [`LDQ_LRQ_SIZE-1:0] lrq_oh_t;
  typedef logic [`LDQ_STQ_SIZE-1:0] stq_mask_t;

  // per-entry replay states
  typedef enum logic [2:0] {
    LDQ_INIT,
    LDQ_TLB_HAZ,
    LDQ_EX2_RUN,
    LDQ_LRQ_HAZ,
    LDQ_STQ_HAZ,
    LDQ_READY,
    LDQ_EX3_DONE,
    LDQ_DEAD
  } ldq_state_t;

  // EX2 result reported by the pipeline
  typedef enum logic [2:0] {
    HAZ_NONE,
    HAZ_L1D_CONFLICT,
    HAZ_LRQ_CONFLICT,
    HAZ_LRQ_FULL,
    HAZ_LRQ_ASSIGNED,
    HAZ_STQ_DEPEND
  } ldq_haz_t;

  // true when a is older than b
  function automatic logic cmt_id_older(input cmt_id_t a, input cmt_id_t b);
    logic low_lt;
    logic wrap_diff;
    low_lt    = a[`LDQ_CMT_ID_W-2:0] < b[`LDQ_CMT_ID_W-2:0];
    wrap_diff = a[`LDQ_CMT_ID_W-1] ^ b[`LDQ_CMT_ID_W-1];
    // ids on opposite sides of a wrap compare the other way round
    return low_lt ^ wrap_diff;
  endfunction

endpackage

/* hdl/ldq_addr_check.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_addr_check
  import ldq_pkg::*;
(
  input  cmt_id_t                 i_entry_cmt_id,
  input  logic [`LDQ_ADDR_W-1:0]  i_entry_paddr,
  input  logic [1:0]              i_entry_size,
  input  logic                    i_st_chk_valid,
  input  cmt_id_t                 i_st_chk_cmt_id,
  input  logic [`LDQ_ADDR_W-1:0]  i_st_chk_paddr,
  input  logic [1:0]              i_st_chk_size,
  output logic                    o_conflict
);

  logic [7:0] w_entry_bytes;
  logic [7:0] w_st_bytes;
  logic       w_same_dword;
  logic       w_st_older;

  // bytes touched inside the 8-byte word from the size-aligned offset
  function automatic logic [7:0] byte_mask(input logic [2:0] offs, input logic [1:0] size);
    logic [7:0] base;
    logic [2:0] aligned;
    case (size)
      2'd0:    base = 8'h01;
      2'd1:    base = 8'h03;
      2'd2:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    aligned = offs & ~((3'd1 << size) - 3'd1);
    return base << aligned;
  endfunction

  assign w_entry_bytes = byte_mask(i_entry_paddr[2:0], i_entry_size);
  assign w_st_bytes    = byte_mask(i_st_chk_paddr[2:0], i_st_chk_size);
  assign w_same_dword  = i_entry_paddr[`LDQ_ADDR_W-1:3] == i_st_chk_paddr[`LDQ_ADDR_W-1:3];
  assign w_st_older    = cmt_id_older(i_st_chk_cmt_id, i_entry_cmt_id);

  assign o_conflict = i_st_chk_valid & w_st_older & w_same_dword & |(w_entry_bytes & w_st_bytes);

endmodule

/* hdl/ldq_entry.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_entry
  import ldq_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_disp_load,
  input  cmt_id_t                 i_disp_cmt_id,

  input  logic                    i_ex1_valid,
  input  logic [`LDQ_ADDR_W-1:0]  i_ex1_vaddr,
  input  logic [`LDQ_ADDR_W-1:0]  i_ex1_paddr,
  input  logic [1:0]              i_ex1_size,
  input  logic                    i_ex1_tlb_miss,

  input  logic                    i_tlb_resolve,

  input  logic                    i_ex2_valid,
  input  ldq_haz_t                i_ex2_haz,
  input  lrq_oh_t                 i_ex2_lrq_oh,
  input  stq_mask_t               i_ex2_stq_mask,

  input  logic                    i_lrq_resolve_valid,
  input  lrq_oh_t                 i_lrq_resolve_oh,
  input  logic                    i_stq_resolve_valid,
  input  stq_mask_t               i_stq_resolve_oh,

  input  logic                    i_st_chk_valid,
  input  cmt_id_t                 i_st_chk_cmt_id,
  input  logic [`LDQ_ADDR_W-1:0]  i_st_chk_paddr,
  input  logic [1:0]              i_st_chk_size,

  input  logic                    i_rerun_accept,

  input  logic                    i_commit_valid,
  input  cmt_id_t                 i_commit_cmt_id,
  input  logic                    i_commit_flush,
  input  logic                    i_commit_dead,

  output logic                    o_valid,
  output logic                    o_ready,
  output logic [`LDQ_ADDR_W-1:0]  o_vaddr,
  output logic                    o_retire,
  output logic                    o_dead_done
);

  logic                   r_valid;
  ldq_state_t             r_state;
  lrq_oh_t                r_lrq_oh;
  stq_mask_t              r_stq_mask;
  cmt_id_t                r_cmt_id;
  logic [`LDQ_ADDR_W-1:0] r_vaddr;
  logic [`LDQ_ADDR_W-1:0] r_paddr;
  logic [1:0]             r_size;

  logic      w_cmt_match;
  logic      w_flush;
  logic      w_retire;
  logic      w_dead_clear;
  logic      w_ex1_take;
  logic      w_lrq_haz;
  logic      w_lrq_fast;
  logic      w_addr_conflict;
  stq_mask_t w_stq_mask_next;

  assign w_cmt_match  = r_valid & (i_commit_cmt_id == r_cmt_id);
  assign w_flush      = i_commit_valid & i_commit_flush & ~i_commit_dead & r_valid;
  assign w_retire     = i_commit_valid & ~i_commit_dead & w_cmt_match &
                        (r_state == LDQ_EX3_DONE);
  assign w_dead_clear = i_commit_valid & i_commit_dead & w_cmt_match & (r_state == LDQ_DEAD);
  assign w_ex1_take   = i_ex1_valid & r_valid & (r_state == LDQ_INIT);

  assign w_lrq_haz  = (i_ex2_haz == HAZ_LRQ_CONFLICT) | (i_ex2_haz == HAZ_LRQ_FULL);
  // miss entry resolved in the same cycle
  assign w_lrq_fast = (i_ex2_haz == HAZ_LRQ_CONFLICT) & i_lrq_resolve_valid &
                      (i_lrq_resolve_oh == i_ex2_lrq_oh);

  assign w_stq_mask_next = i_stq_resolve_valid ? (r_stq_mask & ~i_stq_resolve_oh) : r_stq_mask;

  ldq_addr_check u_addr_check (
    .i_entry_cmt_id  (r_cmt_id),
    .i_entry_paddr   (r_paddr),
    .i_entry_size    (r_size),
    .i_st_chk_valid  (i_st_chk_valid),
    .i_st_chk_cmt_id (i_st_chk_cmt_id),
    .i_st_chk_paddr  (i_st_chk_paddr),
    .i_st_chk_size   (i_st_chk_size),
    .o_conflict      (w_addr_conflict)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid    <= 1'b0;
      r_state    <= LDQ_INIT;
      r_lrq_oh   <= '0;
      r_stq_mask <= '0;
    end else if (w_flush) begin
      if (w_retire) begin
        r_valid <= 1'b0;
        r_state <= LDQ_INIT;
      end else begin
        r_state <= LDQ_DEAD;
      end
    end else begin
      case (r_state)
        LDQ_INIT: begin
          if (i_disp_load) begin
            r_valid <= 1'b1;
          end else if (w_ex1_take) begin
            r_state <= i_ex1_tlb_miss ? LDQ_TLB_HAZ : LDQ_EX2_RUN;
          end
        end
        LDQ_TLB_HAZ: begin
          if (i_tlb_resolve) r_state <= LDQ_READY;
        end
        LDQ_EX2_RUN: begin
          if (i_ex2_valid) begin
            r_lrq_oh   <= i_ex2_lrq_oh;
            r_stq_mask <= i_ex2_stq_mask;
            if (i_ex2_haz == HAZ_L1D_CONFLICT || i_ex2_haz == HAZ_LRQ_ASSIGNED || w_lrq_fast) begin
              r_state <= LDQ_READY;
            end else if (w_lrq_haz) begin
              r_state <= LDQ_LRQ_HAZ;
            end else if (i_ex2_haz == HAZ_STQ_DEPEND) begin
              r_state <= LDQ_STQ_HAZ;
            end else begin
              r_state <= LDQ_EX3_DONE;
            end
          end
        end
        LDQ_LRQ_HAZ: begin
          if (i_lrq_resolve_valid && i_lrq_resolve_oh == r_lrq_oh) r_state <= LDQ_READY;
        end
        LDQ_STQ_HAZ: begin
          r_stq_mask <= w_stq_mask_next;
          if (w_stq_mask_next == '0) r_state <= LDQ_READY;
        end
        LDQ_READY: begin
          if (i_rerun_accept) r_state <= LDQ_INIT;
        end
        LDQ_EX3_DONE: begin
          if (w_retire) begin
            r_valid <= 1'b0;
            r_state <= LDQ_INIT;
          end else if (w_addr_conflict) begin
            r_state <= LDQ_READY; // older store hit our bytes
          end
        end
        LDQ_DEAD: begin
          if (w_dead_clear) begin
            r_valid <= 1'b0;
            r_state <= LDQ_INIT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_load) r_cmt_id <= i_disp_cmt_id;
    if (w_ex1_take) begin
      r_vaddr <= i_ex1_vaddr;
      r_paddr <= i_ex1_paddr;
      r_size  <= i_ex1_size;
    end
  end

  assign o_valid     = r_valid;
  assign o_ready     = r_valid & (r_state == LDQ_READY);
  assign o_vaddr     = r_vaddr;
  assign o_retire    = w_retire;
  assign o_dead_done = w_dead_clear;

  a_assigned_no_lrq: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex2_valid && i_ex2_haz == HAZ_LRQ_ASSIGNED |-> i_ex2_lrq_oh == '0);

  a_lrq_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex2_valid && w_lrq_haz |-> $onehot0(i_ex2_lrq_oh));

  // index decode upstream must never hit a free slot
  a_update_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex1_valid || i_ex2_valid |-> r_valid);

endmodule

/* hdl/ldq_rerun_pick.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_rerun_pick
  import ldq_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic [`LDQ_SIZE-1:0]  i_req,
  input  logic                  i_accept,
  output logic                  o_valid,
  output ldq_idx_t              o_index
);

  ldq_idx_t             r_ptr;
  ldq_idx_t             w_scan_idx [`LDQ_SIZE];
  logic [`LDQ_SIZE-1:0] w_grant_oh;
  ldq_idx_t             w_index;

  // scan order starts at the pointer and wraps
  for (genvar g = 0; g < `LDQ_SIZE; g++) begin : g_scan
    assign w_scan_idx[g] = r_ptr + ldq_idx_t'(g);
  end

  always_comb begin
    logic found;
    found      = 1'b0;
    w_grant_oh = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (!found && i_req[w_scan_idx[i]]) begin
        found                  = 1'b1;
        w_grant_oh[w_scan_idx[i]] = 1'b1;
      end
    end
  end

  always_comb begin
    w_index = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (w_grant_oh[i]) w_index = w_index | ldq_idx_t'(i);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr <= '0;
    end else if (o_valid) begin
      // park on the offer until it is taken
      r_ptr <= i_accept ? w_index + ldq_idx_t'(1) : w_index;
    end
  end

  assign o_valid = |w_grant_oh;
  assign o_index = w_index;

  a_grant_is_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> i_req[o_index]);

endmodule

/* hdl/ldq_top.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_top
  import ldq_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_disp_valid,
  input  cmt_id_t                 i_disp_cmt_id,

  input  logic                    i_ex1_valid,
  input  ldq_idx_t                i_ex1_index,
  input  logic [`LDQ_ADDR_W-1:0]  i_ex1_vaddr,
  input  logic [`LDQ_ADDR_W-1:0]  i_ex1_paddr,
  input  logic [1:0]              i_ex1_size,
  input  logic                    i_ex1_tlb_miss,

  input  logic                    i_tlb_resolve,

  input  logic                    i_ex2_valid,
  input  ldq_idx_t                i_ex2_index,
  input  ldq_haz_t                i_ex2_haz,
  input  lrq_oh_t                 i_ex2_lrq_oh,
  input  stq_mask_t               i_ex2_stq_mask,

  input  logic                    i_lrq_resolve_valid,
  input  lrq_oh_t                 i_lrq_resolve_oh,
  input  logic                    i_stq_resolve_valid,
  input  stq_mask_t               i_stq_resolve_oh,

  input  logic                    i_st_chk_valid,
  input  cmt_id_t                 i_st_chk_cmt_id,
  input  logic [`LDQ_ADDR_W-1:0]  i_st_chk_paddr,
  input  logic [1:0]              i_st_chk_size,

  input  logic                    i_rerun_accept,

  input  logic                    i_commit_valid,
  input  cmt_id_t                 i_commit_cmt_id,
  input  logic                    i_commit_flush,
  input  logic                    i_commit_dead,

  output logic                    o_disp_full,
  output ldq_idx_t                o_disp_index,
  output logic                    o_rerun_valid,
  output ldq_idx_t                o_rerun_index,
  output logic [`LDQ_ADDR_W-1:0]  o_rerun_vaddr,
  output logic                    o_retire_valid,
  output ldq_idx_t                o_retire_index,
  output logic                    o_dead_done
);

  logic [`LDQ_SIZE-1:0]   w_valid;
  logic [`LDQ_SIZE-1:0]   w_ready;
  logic [`LDQ_SIZE-1:0]   w_retire;
  logic [`LDQ_SIZE-1:0]   w_dead_done;
  logic [`LDQ_ADDR_W-1:0] w_vaddr [`LDQ_SIZE];
  ldq_idx_t               w_retire_enc;
  logic                   r_retire_valid;
  ldq_idx_t               r_retire_index;

  // lowest free slot
  always_comb begin
    o_disp_index = '0;
    for (int i = `LDQ_SIZE - 1; i >= 0; i--) begin
      if (!w_valid[i]) o_disp_index = ldq_idx_t'(i);
    end
  end

  assign o_disp_full = &w_valid;

  for (genvar g = 0; g < `LDQ_SIZE; g++) begin : g_entry
    ldq_entry u_entry (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_disp_load         (i_disp_valid & ~o_disp_full & (o_disp_index == ldq_idx_t'(g))),
      .i_disp_cmt_id       (i_disp_cmt_id),
      .i_ex1_valid         (i_ex1_valid & (i_ex1_index == ldq_idx_t'(g))),
      .i_ex1_vaddr         (i_ex1_vaddr),
      .i_ex1_paddr         (i_ex1_paddr),
      .i_ex1_size          (i_ex1_size),
      .i_ex1_tlb_miss      (i_ex1_tlb_miss),
      .i_tlb_resolve       (i_tlb_resolve),
      .i_ex2_valid         (i_ex2_valid & (i_ex2_index == ldq_idx_t'(g))),
      .i_ex2_haz           (i_ex2_haz),
      .i_ex2_lrq_oh        (i_ex2_lrq_oh),
      .i_ex2_stq_mask      (i_ex2_stq_mask),
      .i_lrq_resolve_valid (i_lrq_resolve_valid),
      .i_lrq_resolve_oh    (i_lrq_resolve_oh),
      .i_stq_resolve_valid (i_stq_resolve_valid),
      .i_stq_resolve_oh    (i_stq_resolve_oh),
      .i_st_chk_valid      (i_st_chk_valid),
      .i_st_chk_cmt_id     (i_st_chk_cmt_id),
      .i_st_chk_paddr      (i_st_chk_paddr),
      .i_st_chk_size       (i_st_chk_size),
      .i_rerun_accept      (i_rerun_accept & o_rerun_valid &
                            (o_rerun_index == ldq_idx_t'(g))),
      .i_commit_valid      (i_commit_valid),
      .i_commit_cmt_id     (i_commit_cmt_id),
      .i_commit_flush      (i_commit_flush),
      .i_commit_dead       (i_commit_dead),
      .o_valid             (w_valid[g]),
      .o_ready             (w_ready[g]),
      .o_vaddr             (w_vaddr[g]),
      .o_retire            (w_retire[g]),
      .o_dead_done         (w_dead_done[g])
    );
  end

  ldq_rerun_pick u_rerun_pick (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (w_ready),
    .i_accept  (i_rerun_accept),
    .o_valid   (o_rerun_valid),
    .o_index   (o_rerun_index)
  );

  assign o_rerun_vaddr = w_vaddr[o_rerun_index];

  always_comb begin
    w_retire_enc = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (w_retire[i]) w_retire_enc = w_retire_enc | ldq_idx_t'(i);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_retire_valid <= 1'b0;
    end else begin
      r_retire_valid <= |w_retire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (|w_retire) r_retire_index <= w_retire_enc;
  end

  assign o_retire_valid = r_retire_valid;
  assign o_retire_index = r_retire_index;
  assign o_dead_done    = |w_dead_done; // only the matching dead entry fires

  // commit ids are unique, so one retire per commit
  a_one_retire: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_retire));

endmodule

/* dv/ldq_tb.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_tb
  import ldq_pkg::*;
();

  localparam int N          = `LDQ_SIZE;
  localparam int MAX_CYCLES = 3000; // directed stimulus is a few hundred cycles
  localparam int OFFER_WAIT = 20;

  logic i_clk, i_reset_n, i_disp_valid, i_ex1_valid, i_ex1_tlb_miss, i_tlb_resolve;
  logic i_ex2_valid, i_lrq_resolve_valid, i_stq_resolve_valid, i_st_chk_valid;
  logic i_rerun_accept, i_commit_valid, i_commit_flush, i_commit_dead;
  cmt_id_t                i_disp_cmt_id, i_st_chk_cmt_id, i_commit_cmt_id;
  ldq_idx_t               i_ex1_index, i_ex2_index;
  logic [`LDQ_ADDR_W-1:0] i_ex1_vaddr, i_ex1_paddr, i_st_chk_paddr;
  logic [1:0]             i_ex1_size, i_st_chk_size;
  ldq_haz_t               i_ex2_haz;
  lrq_oh_t                i_ex2_lrq_oh, i_lrq_resolve_oh;
  stq_mask_t              i_ex2_stq_mask, i_stq_resolve_oh;
  logic                   o_disp_full, o_rerun_valid, o_retire_valid, o_dead_done;
  ldq_idx_t               o_disp_index, o_rerun_index, o_retire_index;
  logic [`LDQ_ADDR_W-1:0] o_rerun_vaddr;

  // reference model of the queue
  logic                   m_valid [N];
  ldq_state_t             m_state [N];
  cmt_id_t                m_cmt [N];
  lrq_oh_t                m_lrq [N];
  stq_mask_t              m_stq [N];
  logic [`LDQ_ADDR_W-1:0] m_vaddr [N];
  logic [`LDQ_ADDR_W-1:0] m_paddr [N];
  logic [1:0]             m_size [N];
  stq_mask_t              stq_left [N];
  ldq_idx_t               m_ptr, m_ret_idx, exp_disp_idx, exp_rerun_idx, exp_ret_idx;
  logic                   m_ret_valid, exp_full, exp_rerun_valid, exp_dead_done;
  logic [N-1:0]           retire_now, dead_now, conflict;
  int                     value_errs = 0;
  int                     event_errs = 0;
  int                     cycles = 0;

  ldq_top uut (.*);

  always #10 i_clk = ~i_clk;

  function automatic logic is_older(input cmt_id_t a, input cmt_id_t b);
    logic lt;
    lt = a[`LDQ_CMT_ID_W-2:0] < b[`LDQ_CMT_ID_W-2:0];
    return (a[`LDQ_CMT_ID_W-1] != b[`LDQ_CMT_ID_W-1]) ? !lt : lt;
  endfunction

  function automatic logic bytes_overlap(input logic [`LDQ_ADDR_W-1:0] a, input logic [1:0] sa,
                                         input logic [`LDQ_ADDR_W-1:0] b, input logic [1:0] sb);
    longint a_lo, b_lo, a_hi, b_hi;
    a_lo = longint'(a) & ~((longint'(1) << sa) - 1);
    b_lo = longint'(b) & ~((longint'(1) << sb) - 1);
    a_hi = a_lo + (longint'(1) << sa);
    b_hi = b_lo + (longint'(1) << sb);
    return (a_lo < b_hi) && (b_lo < a_hi);
  endfunction

  function automatic ldq_state_t ex2_next_state(input ldq_haz_t haz, input lrq_oh_t oh,
                                               input logic res_valid, input lrq_oh_t res_oh);
    case (haz)
      HAZ_L1D_CONFLICT, HAZ_LRQ_ASSIGNED: return LDQ_READY;
      HAZ_LRQ_CONFLICT: return (res_valid && res_oh == oh) ? LDQ_READY : LDQ_LRQ_HAZ;
      HAZ_LRQ_FULL:     return LDQ_LRQ_HAZ;
      HAZ_STQ_DEPEND:   return LDQ_STQ_HAZ;
      default:          return LDQ_EX3_DONE;
    endcase
  endfunction

  always_comb begin
    ldq_idx_t j;
    exp_full        = 1'b1;
    exp_disp_idx    = '0;
    exp_rerun_valid = 1'b0;
    exp_rerun_idx   = '0;
    exp_ret_idx     = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!m_valid[i]) begin
        exp_full     = 1'b0;
        exp_disp_idx = ldq_idx_t'(i);
      end
    end
    for (int k = 0; k < N; k++) begin
      j = m_ptr + ldq_idx_t'(k); // first ready at or after the pointer
      if (!exp_rerun_valid && m_valid[j] && m_state[j] == LDQ_READY) begin
        exp_rerun_valid = 1'b1;
        exp_rerun_idx   = j;
      end
    end
    for (int i = 0; i < N; i++) begin
      retire_now[i] = i_commit_valid && !i_commit_dead && m_valid[i] &&
                      m_cmt[i] == i_commit_cmt_id && m_state[i] == LDQ_EX3_DONE;
      dead_now[i]   = i_commit_valid && i_commit_dead && m_valid[i] &&
                      m_cmt[i] == i_commit_cmt_id && m_state[i] == LDQ_DEAD;
      conflict[i]   = i_st_chk_valid && m_valid[i] && m_state[i] == LDQ_EX3_DONE &&
                      is_older(i_st_chk_cmt_id, m_cmt[i]) &&
                      bytes_overlap(m_paddr[i], m_size[i], i_st_chk_paddr, i_st_chk_size);
      stq_left[i]   = i_stq_resolve_valid ? (m_stq[i] & ~i_stq_resolve_oh) : m_stq[i];
      if (retire_now[i]) exp_ret_idx = ldq_idx_t'(i);
    end
    exp_dead_done = |dead_now;
  end

  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < N; i++) begin
        m_valid[i] <= 1'b0;
        m_state[i] <= LDQ_INIT;
      end
      m_ptr       <= '0;
      m_ret_valid <= 1'b0;
      m_ret_idx   <= '0;
    end else begin
      m_ret_valid <= |retire_now;
      m_ret_idx   <= exp_ret_idx;
      if (exp_rerun_valid) m_ptr <= i_rerun_accept ? exp_rerun_idx + 1'b1 : exp_rerun_idx;
      for (int i = 0; i < N; i++) begin
        if (m_valid[i] && i_commit_valid && i_commit_flush && !i_commit_dead) begin
          m_valid[i] <= !retire_now[i];
          m_state[i] <= retire_now[i] ? LDQ_INIT : LDQ_DEAD;
        end else if (retire_now[i] || dead_now[i]) begin
          m_valid[i] <= 1'b0;
          m_state[i] <= LDQ_INIT;
        end else if (i_disp_valid && !exp_full && exp_disp_idx == ldq_idx_t'(i)) begin
          m_valid[i] <= 1'b1;
          m_state[i] <= LDQ_INIT;
          m_cmt[i]   <= i_disp_cmt_id;
        end else if (m_valid[i]) begin
          case (m_state[i])
            LDQ_INIT: begin
              if (i_ex1_valid && i_ex1_index == ldq_idx_t'(i)) begin
                m_state[i] <= i_ex1_tlb_miss ? LDQ_TLB_HAZ : LDQ_EX2_RUN;
                m_vaddr[i] <= i_ex1_vaddr;
                m_paddr[i] <= i_ex1_paddr;
                m_size[i]  <= i_ex1_size;
              end
            end
            LDQ_TLB_HAZ: if (i_tlb_resolve) m_state[i] <= LDQ_READY;
            LDQ_EX2_RUN: begin
              if (i_ex2_valid && i_ex2_index == ldq_idx_t'(i)) begin
                m_lrq[i]   <= i_ex2_lrq_oh;
                m_stq[i]   <= i_ex2_stq_mask;
                m_state[i] <= ex2_next_state(i_ex2_haz, i_ex2_lrq_oh,
                                             i_lrq_resolve_valid, i_lrq_resolve_oh);
              end
            end
            LDQ_LRQ_HAZ: begin
              if (i_lrq_resolve_valid && i_lrq_resolve_oh == m_lrq[i]) m_state[i] <= LDQ_READY;
            end
            LDQ_STQ_HAZ: begin
              m_stq[i] <= stq_left[i];
              if (stq_left[i] == '0) m_state[i] <= LDQ_READY;
            end
            LDQ_READY: begin
              if (i_rerun_accept && exp_rerun_idx == ldq_idx_t'(i)) m_state[i] <= LDQ_INIT;
            end
            LDQ_EX3_DONE: if (conflict[i]) m_state[i] <= LDQ_READY;
            default: ;
          endcase
        end
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
  endtask

  a_full: assert property (@(posedge i_clk) disable iff (!i_reset_n) o_disp_full == exp_full)
    else report_mismatch("o_disp_full", 32'($sampled(o_disp_full)), 32'($sampled(exp_full)));
  a_disp_index: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !exp_full |-> o_disp_index == exp_disp_idx)
    else report_mismatch("o_disp_index", 32'($sampled(o_disp_index)),
                         32'($sampled(exp_disp_idx)));
  a_rerun_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_rerun_valid == exp_rerun_valid)
    else report_mismatch("o_rerun_valid", 32'($sampled(o_rerun_valid)),
                         32'($sampled(exp_rerun_valid)));
  a_rerun_index: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_rerun_valid |-> o_rerun_index == exp_rerun_idx)
    else report_mismatch("o_rerun_index", 32'($sampled(o_rerun_index)),
                         32'($sampled(exp_rerun_idx)));
  a_rerun_vaddr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_rerun_valid |-> o_rerun_vaddr == m_vaddr[exp_rerun_idx])
    else report_mismatch("o_rerun_vaddr", 32'($sampled(o_rerun_vaddr)),
                         32'($sampled(m_vaddr[exp_rerun_idx])));
  a_retire_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_retire_valid == m_ret_valid)
    else report_mismatch("o_retire_valid", 32'($sampled(o_retire_valid)),
                         32'($sampled(m_ret_valid)));
  a_retire_index: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    m_ret_valid |-> o_retire_index == m_ret_idx)
    else report_mismatch("o_retire_index", 32'($sampled(o_retire_index)),
                         32'($sampled(m_ret_idx)));
  a_dead_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_dead_done == exp_dead_done)
    else report_mismatch("o_dead_done", 32'($sampled(o_dead_done)),
                         32'($sampled(exp_dead_done)));

  function automatic logic [`LDQ_ADDR_W-1:0] rand_paddr(input logic [1:0] size);
    return $urandom & ~((32'd1 << size) - 32'd1); // naturally aligned
  endfunction

  task automatic dispatch_load(input cmt_id_t id);
    i_disp_valid  = 1'b1;
    i_disp_cmt_id = id;
    @(negedge i_clk);
    i_disp_valid  = 1'b0;
  endtask

  task automatic issue_ex1(input ldq_idx_t idx, input logic [`LDQ_ADDR_W-1:0] paddr,
                           input logic [1:0] size, input logic miss);
    i_ex1_valid    = 1'b1;
    i_ex1_index    = idx;
    i_ex1_vaddr    = $urandom;
    i_ex1_paddr    = paddr;
    i_ex1_size     = size;
    i_ex1_tlb_miss = miss;
    @(negedge i_clk);
    i_ex1_valid    = 1'b0;
  endtask

  task automatic report_ex2(input ldq_idx_t idx, input ldq_haz_t haz, input lrq_oh_t oh,
                            input stq_mask_t mask);
    i_ex2_valid    = 1'b1;
    i_ex2_index    = idx;
    i_ex2_haz      = haz;
    i_ex2_lrq_oh   = oh;
    i_ex2_stq_mask = mask;
    @(negedge i_clk);
    i_ex2_valid    = 1'b0;
  endtask

  task automatic run_clean(input ldq_idx_t idx);
    issue_ex1(idx, rand_paddr(2'd2), 2'd2, 1'b0);
    report_ex2(idx, HAZ_NONE, '0, '0);
  endtask

  task automatic resolve_tlb();
    i_tlb_resolve = 1'b1;
    @(negedge i_clk);
    i_tlb_resolve = 1'b0;
  endtask

  task automatic resolve_lrq(input lrq_oh_t oh);
    i_lrq_resolve_valid = 1'b1;
    i_lrq_resolve_oh    = oh;
    @(negedge i_clk);
    i_lrq_resolve_valid = 1'b0;
  endtask

  task automatic resolve_stq(input stq_mask_t oh);
    i_stq_resolve_valid = 1'b1;
    i_stq_resolve_oh    = oh;
    @(negedge i_clk);
    i_stq_resolve_valid = 1'b0;
  endtask

  task automatic check_store(input cmt_id_t id, input logic [`LDQ_ADDR_W-1:0] paddr,
                             input logic [1:0] size);
    i_st_chk_valid  = 1'b1;
    i_st_chk_cmt_id = id;
    i_st_chk_paddr  = paddr;
    i_st_chk_size   = size;
    @(negedge i_clk);
    i_st_chk_valid  = 1'b0;
  endtask

  task automatic accept_rerun();
    int waited;
    waited = 0;
    while (!o_rerun_valid && waited < OFFER_WAIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_rerun_valid) begin
      event_errs++;
      $display("no rerun was offered within %0d cycles", OFFER_WAIT);
    end else begin
      i_rerun_accept = 1'b1;
      @(negedge i_clk);
      i_rerun_accept = 1'b0;
    end
  endtask

  task automatic commit_load(input cmt_id_t id, input logic flush, input logic dead);
    i_commit_valid  = 1'b1;
    i_commit_cmt_id = id;
    i_commit_flush  = flush;
    i_commit_dead   = dead;
    @(negedge i_clk);
    i_commit_valid  = 1'b0;
  endtask

  task automatic print_error_counts();
    $display("errors: %0d value mismatches, %0d missing events", value_errs, event_errs);
  endtask

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped by timeout after %0d cycles", cycles);
      print_error_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9155_46ce));
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    {i_disp_valid, i_ex1_valid, i_ex1_tlb_miss, i_tlb_resolve, i_ex2_valid} = '0;
    {i_lrq_resolve_valid, i_stq_resolve_valid, i_st_chk_valid, i_rerun_accept} = '0;
    {i_commit_valid, i_commit_flush, i_commit_dead} = '0;
    {i_disp_cmt_id, i_st_chk_cmt_id, i_commit_cmt_id, i_ex1_index, i_ex2_index} = '0;
    {i_ex1_vaddr, i_ex1_paddr, i_st_chk_paddr, i_ex1_size, i_st_chk_size} = '0;
    {i_ex2_lrq_oh, i_lrq_resolve_oh, i_ex2_stq_mask, i_stq_resolve_oh} = '0;
    i_ex2_haz = HAZ_NONE;
    repeat (16) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    // fill all four slots, free slot 2 first
    for (int i = 0; i < N; i++) begin
      dispatch_load(cmt_id_t'(i + 1));
    end
    run_clean(2'd2);
    commit_load(6'd3, 1'b0, 1'b0);
    run_clean(2'd0);
    run_clean(2'd1);
    run_clean(2'd3);
    commit_load(6'd1, 1'b0, 1'b0);
    commit_load(6'd2, 1'b0, 1'b0);
    commit_load(6'd4, 1'b0, 1'b0);

    // tlb miss replay, then two bank conflicts offered in turn
    dispatch_load(6'd10);
    issue_ex1(2'd0, rand_paddr(2'd2), 2'd2, 1'b1);
    repeat (3) @(negedge i_clk);
    resolve_tlb();
    accept_rerun();
    dispatch_load(6'd11);
    issue_ex1(2'd0, rand_paddr(2'd3), 2'd3, 1'b0);
    issue_ex1(2'd1, rand_paddr(2'd1), 2'd1, 1'b0);
    report_ex2(2'd0, HAZ_L1D_CONFLICT, '0, '0);
    report_ex2(2'd1, HAZ_L1D_CONFLICT, '0, '0);
    repeat (2) @(negedge i_clk); // offer must hold without accept
    accept_rerun();
    accept_rerun();
    run_clean(2'd0);
    run_clean(2'd1);
    commit_load(6'd10, 1'b0, 1'b0);
    commit_load(6'd11, 1'b0, 1'b0);

    // miss queue and store queue waits
    dispatch_load(6'd12);
    dispatch_load(6'd13);
    issue_ex1(2'd0, rand_paddr(2'd2), 2'd2, 1'b0);
    issue_ex1(2'd1, rand_paddr(2'd2), 2'd2, 1'b0);
    report_ex2(2'd0, HAZ_LRQ_CONFLICT, 4'b0010, '0);
    report_ex2(2'd1, HAZ_STQ_DEPEND, '0, 8'b0000_0101);
    resolve_lrq(4'b0100);
    resolve_stq(8'b0000_0001);
    repeat (2) @(negedge i_clk);
    resolve_lrq(4'b0010);
    accept_rerun();
    resolve_stq(8'b0000_0100);
    accept_rerun();
    issue_ex1(2'd0, rand_paddr(2'd2), 2'd2, 1'b0);
    report_ex2(2'd0, HAZ_LRQ_ASSIGNED, '0, '0);
    accept_rerun();
    run_clean(2'd0);
    run_clean(2'd1);
    commit_load(6'd12, 1'b0, 1'b0);
    commit_load(6'd13, 1'b0, 1'b0);

    // store ordering against an executed load
    dispatch_load(6'd20);
    issue_ex1(2'd0, 32'h0000_1040, 2'd2, 1'b0);
    report_ex2(2'd0, HAZ_NONE, '0, '0);
    check_store(6'd21, 32'h0000_1040, 2'd2);
    check_store(6'd19, 32'h0000_1048, 2'd2);
    @(negedge i_clk);
    check_store(6'd19, 32'h0000_1042, 2'd1);
    accept_rerun();
    run_clean(2'd0);
    commit_load(6'd20, 1'b0, 1'b0);

    // flush with entries in several states
    for (int i = 0; i < N; i++) begin
      dispatch_load(cmt_id_t'(30 + i));
    end
    run_clean(2'd1);
    issue_ex1(2'd2, rand_paddr(2'd2), 2'd2, 1'b1);
    issue_ex1(2'd3, rand_paddr(2'd2), 2'd2, 1'b0);
    report_ex2(2'd3, HAZ_L1D_CONFLICT, '0, '0);
    commit_load(6'd31, 1'b1, 1'b0);
    dispatch_load(6'd34);
    commit_load(6'd30, 1'b0, 1'b1);
    commit_load(6'd32, 1'b0, 1'b1);
    commit_load(6'd33, 1'b0, 1'b1);
    run_clean(2'd1);
    commit_load(6'd34, 1'b0, 1'b0);
    repeat (4) @(negedge i_clk);

    print_error_counts();
    if (value_errs == 0 && event_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* ldq.f */
+incdir+hdl
hdl/ldq_pkg.sv
hdl/ldq_addr_check.sv
hdl/ldq_entry.sv
hdl/ldq_rerun_pick.sv
hdl/ldq_top.sv
dv/ldq_tb.sv

/* run.sh */
#!/bin/sh
# build and run the load queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f ldq.f --top-module ldq_tb -o ldq_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/ldq_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
